// ==== source/char_pkg.sv ====
package char_pkg;

    typedef logic [10:0] coord_t;       // screen pixel coordinate
    typedef logic [1:0]  wb_addr_t;     // host register index

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
        logic up;
        logic down;
        logic start;
    } key_cmd_t;

    typedef struct packed {
        coord_t xpos;
        coord_t ypos;
    } char_pos_t;

    typedef struct packed {
        logic on_ladder;
        logic airborne;
        logic busy;
    } char_status_t;

    // screen
    localparam coord_t HOR_PIXELS  = 11'd800;
    localparam coord_t CHAR_WIDTH  = 11'd32;
    localparam coord_t START_XPOS  = 11'd100;
    localparam coord_t START_YPOS  = 11'd500;
    localparam coord_t JUMP_HEIGHT = 11'd24;

    // level map, y grows downwards
    localparam coord_t FLOOR_Y0 = 11'd500;  // bottom
    localparam coord_t FLOOR_Y1 = 11'd400;
    localparam coord_t FLOOR_Y2 = 11'd300;  // top
    localparam coord_t LADDER_X_LO = 11'd300;
    localparam coord_t LADDER_X_HI = 11'd316;

    // host readout
    localparam wb_addr_t WB_ADDR_POS    = 2'd0;  // {ypos, xpos}
    localparam wb_addr_t WB_ADDR_STATUS = 2'd1;

endpackage

// ==== source/key_decoder.sv ====
`timescale 1ns/1ns

module key_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               left,
    input  logic               right,
    input  logic               jump,
    input  logic               up,
    input  logic               down,
    input  logic               start_game,
    input  logic               hit,
    output char_pkg::key_cmd_t key,
    output logic               hit_sync
);

    import char_pkg::*;

    key_cmd_t raw;
    key_cmd_t meta;
    key_cmd_t stable;
    logic     hit_meta;
    logic     hit_stable;
    logic     started;
    logic     started_nxt;

    assign raw = '{
        left:  left,
        right: right,
        jump:  jump,
        up:    up,
        down:  down,
        start: start_game
    };

    // latched start, includes the cycle it is first seen
    assign started_nxt = started | stable.start;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta       <= '0;
            stable     <= '0;
            hit_meta   <= 1'b0;
            hit_stable <= 1'b0;
        end else begin
            meta       <= raw;      // first sync stage
            stable     <= meta;
            hit_meta   <= hit;
            hit_stable <= hit_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started  <= 1'b0;
            key      <= '0;
            hit_sync <= 1'b0;
        end else begin
            started   <= started_nxt;
            key.left  <= stable.left  & started_nxt;   // masked until start
            key.right <= stable.right & started_nxt;
            key.jump  <= stable.jump  & started_nxt;
            key.up    <= stable.up    & started_nxt;
            key.down  <= stable.down  & started_nxt;
            key.start <= started_nxt;
            hit_sync  <= hit_stable;
        end
    end

endmodule

// ==== source/map_control.sv ====
`timescale 1ns/1ns

module map_control (
    input  char_pkg::char_pos_t pos,
    output logic                ladder,
    output char_pkg::coord_t    floor_above,
    output char_pkg::coord_t    floor_below
);

    import char_pkg::*;

    coord_t right_edge;
    logic   left_of_ladder;
    logic   right_of_ladder;

    assign right_edge = pos.xpos + CHAR_WIDTH;

    // sprite box vs ladder column
    assign left_of_ladder  = (right_edge <= LADDER_X_LO);
    assign right_of_ladder = (pos.xpos >= LADDER_X_HI);
    assign ladder          = !left_of_ladder && !right_of_ladder;

    // nearest row strictly above y
    always_comb begin
        if (pos.ypos > FLOOR_Y0) begin
            floor_above = FLOOR_Y0;
        end else if (pos.ypos > FLOOR_Y1) begin
            floor_above = FLOOR_Y1;
        end else begin
            floor_above = FLOOR_Y2;     // also the clamp at the top
        end
    end

    // nearest row strictly below y
    always_comb begin
        if (pos.ypos < FLOOR_Y2) begin
            floor_below = FLOOR_Y2;
        end else if (pos.ypos < FLOOR_Y1) begin
            floor_below = FLOOR_Y1;
        end else begin
            floor_below = FLOOR_Y0;     // also the clamp at the bottom
        end
    end

endmodule

// ==== source/char_movement.sv ====
`timescale 1ns/1ns

module char_movement #(
    parameter int STEP_DIV = 3,
    parameter int JUMP_DIV = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  char_pkg::key_cmd_t     key,
    input  logic                   hit_sync,
    input  logic                   ladder,
    input  char_pkg::coord_t       floor_above,
    input  char_pkg::coord_t       floor_below,
    output char_pkg::char_pos_t    pos,
    output char_pkg::char_status_t status
);

    import char_pkg::*;

    localparam int     STEP_W = (STEP_DIV > 0) ? $clog2(STEP_DIV + 1) : 1;
    localparam int     JUMP_W = (JUMP_DIV > 0) ? $clog2(JUMP_DIV + 1) : 1;
    localparam coord_t X_MAX  = HOR_PIXELS - CHAR_WIDTH;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_IDLE_LADDER,
        ST_GO_LEFT,
        ST_GO_RIGHT,
        ST_JUMP,
        ST_FALL,
        ST_GO_UP,
        ST_GO_DOWN,
        ST_RESTART
    } state_t;

    state_t            state;
    state_t            state_nxt;
    char_pos_t         pos_nxt;
    char_status_t      status_nxt;
    logic [STEP_W-1:0] step_cnt;
    logic [JUMP_W-1:0] vert_cnt;
    logic [JUMP_W-1:0] vert_cnt_nxt;
    coord_t            vel;
    coord_t            vel_nxt;
    coord_t            save_y;
    coord_t            save_y_nxt;
    coord_t            apex_y;
    coord_t            drift_x;
    logic              climb_done;
    logic              climb_done_nxt;
    logic              tick;
    logic              vert_tick;
    logic              on_floor;

    assign tick      = (step_cnt == STEP_W'(STEP_DIV));
    assign vert_tick = tick && (vert_cnt == JUMP_W'(JUMP_DIV));
    assign apex_y    = save_y - JUMP_HEIGHT;
    assign on_floor  = (pos.ypos == FLOOR_Y0) || (pos.ypos == FLOOR_Y1) ||
                       (pos.ypos == FLOOR_Y2);

    // free running step pacing
    always_ff @(posedge clk) begin
        if (rst) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= tick ? '0 : step_cnt + 1'b1;
        end
    end

    // sideways drift while airborne
    always_comb begin
        drift_x = pos.xpos;
        if (key.left && (pos.xpos != '0)) begin
            drift_x = pos.xpos - 1'b1;
        end else if (key.right && (pos.xpos < X_MAX)) begin
            drift_x = pos.xpos + 1'b1;
        end
    end

    always_comb begin
        state_nxt      = state;
        pos_nxt        = pos;
        vel_nxt        = vel;
        save_y_nxt     = save_y;
        vert_cnt_nxt   = vert_cnt;
        climb_done_nxt = climb_done;
        case (state)
            ST_IDLE: begin
                if (key.jump) begin
                    state_nxt    = ST_JUMP;
                    save_y_nxt   = pos.ypos;    // landing row
                    vel_nxt      = coord_t'(1);
                    vert_cnt_nxt = '0;
                end else if (key.up && ladder && (pos.ypos > floor_above)) begin
                    state_nxt      = ST_GO_UP;
                    climb_done_nxt = 1'b0;
                end else if (key.down && ladder && (pos.ypos < floor_below)) begin
                    state_nxt      = ST_GO_DOWN;
                    climb_done_nxt = 1'b0;
                end else if (key.left) begin
                    state_nxt = ST_GO_LEFT;
                end else if (key.right) begin
                    state_nxt = ST_GO_RIGHT;
                end
            end
            ST_GO_LEFT: begin
                if (!key.left) begin
                    state_nxt = ST_IDLE;
                end else if (tick && (pos.xpos != '0)) begin
                    pos_nxt.xpos = pos.xpos - 1'b1;
                end
            end
            ST_GO_RIGHT: begin
                if (!key.right) begin
                    state_nxt = ST_IDLE;
                end else if (tick && (pos.xpos < X_MAX)) begin
                    pos_nxt.xpos = pos.xpos + 1'b1;
                end
            end
            ST_JUMP: begin
                if (tick) begin
                    pos_nxt.xpos = drift_x;
                    vert_cnt_nxt = vert_tick ? '0 : vert_cnt + 1'b1;
                end
                if (vert_tick) begin
                    if ((pos.ypos - vel) <= apex_y) begin
                        pos_nxt.ypos = apex_y;  // clamp at apex, start falling
                        vel_nxt      = coord_t'(1);
                        state_nxt    = ST_FALL;
                    end else begin
                        pos_nxt.ypos = pos.ypos - vel;
                        vel_nxt      = vel + 1'b1;
                    end
                end
            end
            ST_FALL: begin
                if (tick) begin
                    pos_nxt.xpos = drift_x;
                    vert_cnt_nxt = vert_tick ? '0 : vert_cnt + 1'b1;
                end
                if (vert_tick) begin
                    if ((pos.ypos + vel) >= save_y) begin
                        pos_nxt.ypos = save_y;
                        vel_nxt      = '0;
                        state_nxt    = ST_IDLE;
                    end else begin
                        pos_nxt.ypos = pos.ypos + vel;
                        vel_nxt      = vel + 1'b1;
                    end
                end
            end
            ST_GO_UP: begin
                if (!key.up) begin
                    state_nxt = ST_IDLE_LADDER;
                end else if (tick) begin
                    if ((pos.ypos - 1'b1) <= floor_above) begin
                        pos_nxt.ypos   = floor_above;
                        climb_done_nxt = 1'b1;
                        state_nxt      = ST_IDLE_LADDER;
                    end else begin
                        pos_nxt.ypos = pos.ypos - 1'b1;
                    end
                end
            end
            ST_GO_DOWN: begin
                if (!key.down) begin
                    state_nxt = ST_IDLE_LADDER;
                end else if (tick) begin
                    if ((pos.ypos + 1'b1) >= floor_below) begin
                        pos_nxt.ypos   = floor_below;
                        climb_done_nxt = 1'b1;
                        state_nxt      = ST_IDLE_LADDER;
                    end else begin
                        pos_nxt.ypos = pos.ypos + 1'b1;
                    end
                end
            end
            ST_IDLE_LADDER: begin
                if (!key.up && !key.down) begin
                    climb_done_nxt = 1'b0;      // wait for release after a stop
                    if (on_floor) begin
                        state_nxt = ST_IDLE;
                    end
                end else if (!climb_done) begin
                    if (key.up && (pos.ypos > floor_above)) begin
                        state_nxt = ST_GO_UP;
                    end else if (key.down && (pos.ypos < floor_below)) begin
                        state_nxt = ST_GO_DOWN;
                    end
                end
            end
            ST_RESTART: begin
                pos_nxt        = '{xpos: START_XPOS, ypos: START_YPOS};
                vel_nxt        = '0;
                save_y_nxt     = START_YPOS;
                vert_cnt_nxt   = '0;
                climb_done_nxt = 1'b0;
                state_nxt      = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
        if (hit_sync) begin
            state_nxt = ST_RESTART;     // overrides any move
        end
    end

    always_comb begin
        status_nxt.on_ladder = state_nxt inside {ST_IDLE_LADDER, ST_GO_UP, ST_GO_DOWN};
        status_nxt.airborne  = state_nxt inside {ST_JUMP, ST_FALL};
        status_nxt.busy      = (state_nxt != ST_IDLE);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            pos        <= '{xpos: START_XPOS, ypos: START_YPOS};
            status     <= '0;
            vel        <= '0;
            save_y     <= START_YPOS;
            vert_cnt   <= '0;
            climb_done <= 1'b0;
        end else begin
            state      <= state_nxt;
            pos        <= pos_nxt;
            status     <= status_nxt;
            vel        <= vel_nxt;
            save_y     <= save_y_nxt;
            vert_cnt   <= vert_cnt_nxt;
            climb_done <= climb_done_nxt;
        end
    end

endmodule

// ==== source/pos_wb_slave.sv ====
`timescale 1ns/1ns

module pos_wb_slave (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  char_pkg::wb_addr_t     adr,
    output logic [31:0]            dat_r,
    output logic                   ack,
    input  char_pkg::char_pos_t    pos,
    input  char_pkg::char_status_t status
);

    import char_pkg::*;

    localparam int STATUS_PAD = 32 - $bits(char_status_t);

    logic        req;
    logic [31:0] rd_word;

    // new request only, no second ack on a held strobe
    assign req = cyc && stb && !ack;

    always_comb begin
        case (adr)
            WB_ADDR_POS: begin
                rd_word = {5'd0, pos.ypos, 5'd0, pos.xpos};
            end
            WB_ADDR_STATUS: begin
                rd_word = {{STATUS_PAD{1'b0}}, status};
            end
            default: begin
                rd_word = '0;   // unmapped
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= we ? '0 : rd_word;    // writes are dropped
        end
    end

endmodule

// ==== source/char_top.sv ====
`timescale 1ns/1ns

module char_top #(
    parameter int STEP_DIV = 3,
    parameter int JUMP_DIV = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               left,
    input  logic               right,
    input  logic               jump,
    input  logic               up,
    input  logic               down,
    input  logic               start_game,
    input  logic               hit,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  char_pkg::wb_addr_t adr,
    output logic [31:0]        dat_r,
    output logic               ack
);

    import char_pkg::*;

    key_cmd_t     key;
    logic         hit_sync;
    char_pos_t    pos;
    char_status_t status;
    logic         ladder;
    coord_t       floor_above;
    coord_t       floor_below;

    key_decoder i_key_decoder (
        .clk,
        .rst,
        .left,
        .right,
        .jump,
        .up,
        .down,
        .start_game,
        .hit,
        .key,
        .hit_sync
    );

    map_control i_map_control (
        .pos,
        .ladder,
        .floor_above,
        .floor_below
    );

    char_movement #(
        .STEP_DIV(STEP_DIV),
        .JUMP_DIV(JUMP_DIV)
    ) i_char_movement (
        .clk,
        .rst,
        .key,
        .hit_sync,
        .ladder,
        .floor_above,
        .floor_below,
        .pos,
        .status
    );

    pos_wb_slave i_pos_wb_slave (
        .clk,
        .rst,
        .cyc,
        .stb,
        .we,
        .adr,
        .dat_r,
        .ack,
        .pos,
        .status
    );

endmodule

// ==== tests/char_top_tb.sv ====
`timescale 1ns/1ns

module char_top_tb;

    import char_pkg::*;

    localparam int     STEP_DIV   = 3;
    localparam int     JUMP_DIV   = 2;
    localparam int     TICK       = STEP_DIV + 1;
    localparam int     MAX_CYCLES = 20000;     // about 9k of walking and climbing, doubled
    localparam coord_t X_MAX      = HOR_PIXELS - CHAR_WIDTH;

    logic        clk;
    logic        rst;
    logic        left;
    logic        right;
    logic        jump;
    logic        up;
    logic        down;
    logic        start_game;
    logic        hit;
    logic        cyc;
    logic        stb;
    logic        we;
    wb_addr_t    adr;
    logic [31:0] dat_r;
    logic        ack;

    int          mismatches;
    int          failures;
    int          cycles;
    int          last_read;     // cycle of the latest bus capture
    int          last_t;
    coord_t      last_x;
    logic [15:0] lfsr;

    char_top #(
        .STEP_DIV(STEP_DIV),
        .JUMP_DIV(JUMP_DIV)
    ) i_dut (
        .clk,
        .rst,
        .left,
        .right,
        .jump,
        .up,
        .down,
        .start_game,
        .hit,
        .cyc,
        .stb,
        .we,
        .adr,
        .dat_r,
        .ack
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // one ack per strobe
    assert property (@(posedge clk) disable iff (rst) !(ack && $past(ack)))
        else count_failure("Wishbone ack stayed high for two cycles");
    assert property (@(posedge clk) disable iff (rst) ack |-> $past(cyc && stb))
        else count_failure("Wishbone ack without a strobe");

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic count_failure(input string msg);
        failures++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        next_lfsr = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);       // one step per bit
            val  = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    task automatic skip_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic bus_cycle(input wb_addr_t a, input logic write, output logic [31:0] d);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= write;
        adr <= a;
        do begin
            @(posedge clk);
            waited++;
        end while (!ack && waited < 8);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        d         = dat_r;
        last_read = cycles;
        if (!ack) begin
            count_failure("Wishbone strobe got no ack within 8 cycles");
        end else begin
            assert (waited <= 2)
                else count_failure($sformatf("Wishbone ack came after %0d cycles", waited));
        end
    endtask

    task automatic position_now(output coord_t x, output coord_t y);
        logic [31:0] d;
        bus_cycle(WB_ADDR_POS, 1'b0, d);
        x = d[10:0];            // xpos in the low half
        y = d[26:16];
    endtask

    task automatic status_now(output char_status_t st);
        logic [31:0] d;
        bus_cycle(WB_ADDR_STATUS, 1'b0, d);
        st = d[2:0];
    endtask

    // x moves one way only, at most one pixel per started tick
    task automatic track_walk(input logic to_right);
        coord_t x;
        coord_t y;
        int     dt;
        int     moved;
        position_now(x, y);
        dt    = last_read - last_t;
        moved = to_right ? int'(x) - int'(last_x) : int'(last_x) - int'(x);
        assert (moved >= 0 && moved <= (dt + TICK - 1) / TICK)
            else report_mismatch($sformatf("x went %0d -> %0d in %0d cycles", last_x, x, dt));
        assert (x <= X_MAX)
            else report_mismatch($sformatf("x %0d beyond the right edge %0d", x, X_MAX));
        last_x = x;
        last_t = last_read;
    endtask

    task automatic hit_to_start(input string where);
        coord_t       x;
        coord_t       y;
        char_status_t st;
        int           guard;
        hit <= 1'b1;
        skip_cycles(2);
        hit <= 1'b0;
        guard = 0;
        do begin
            position_now(x, y);
            guard++;
        end while ((x != START_XPOS || y != START_YPOS) && guard < 6);
        assert (x == START_XPOS && y == START_YPOS)
            else report_mismatch($sformatf("hit %s left pos at (%0d,%0d)", where, x, y));
        skip_cycles(4);
        status_now(st);
        assert (st == '0)
            else report_mismatch($sformatf("status %b after hit %s", st, where));
    endtask

    initial begin
        logic [31:0]  word;
        logic [31:0]  pos_word;
        logic [31:0]  expect_word;
        coord_t       x;
        coord_t       y;
        coord_t       y0;
        coord_t       prev_y;
        coord_t       min_y;
        char_status_t st;
        wb_addr_t     a;
        int           guard;
        int           hold;
        logic         seen_air;

        mismatches = 0;
        failures   = 0;
        cycles     = 0;
        last_read  = 0;
        last_t     = 0;
        last_x     = '0;
        lfsr       = 16'd47491;
        rst        <= 1'b1;
        left       <= 1'b0;
        right      <= 1'b0;
        jump       <= 1'b0;
        up         <= 1'b0;
        down       <= 1'b0;
        start_game <= 1'b0;
        hit        <= 1'b0;
        cyc        <= 1'b0;
        stb        <= 1'b0;
        we         <= 1'b0;
        adr        <= '0;
        skip_cycles(3);
        rst <= 1'b0;

        // buttons are ignored before start
        right <= 1'b1;
        jump  <= 1'b1;
        up    <= 1'b1;
        skip_cycles(20);
        position_now(x, y);
        assert (x == START_XPOS && y == START_YPOS)
            else report_mismatch($sformatf("pos (%0d,%0d) before start", x, y));
        status_now(st);
        assert (st == '0) else report_mismatch($sformatf("status %b before start", st));
        right <= 1'b0;
        jump  <= 1'b0;
        up    <= 1'b0;
        skip_cycles(6);
        start_game <= 1'b1;
        skip_cycles(4);
        start_game <= 1'b0;
        skip_cycles(6);

        // random length right walks
        position_now(last_x, y);
        last_t = last_read;
        for (int seg = 0; seg < 6; seg++) begin
            hold = random_bits(5) + 4;
            right <= 1'b1;
            for (int r = 0; r < hold; r++) begin
                track_walk(1'b1);
            end
            right <= 1'b0;
            skip_cycles(12);
            position_now(last_x, y);
            last_t = last_read;
        end

        right <= 1'b1;
        guard = 0;
        while (last_x != X_MAX && guard < 1500) begin
            track_walk(1'b1);
            guard++;
        end
        for (int r = 0; r < 10; r++) begin
            track_walk(1'b1);
        end
        assert (last_x == X_MAX)
            else report_mismatch($sformatf("right walk stuck at x %0d", last_x));
        right <= 1'b0;
        skip_cycles(12);
        position_now(last_x, y);
        last_t = last_read;

        left <= 1'b1;
        guard = 0;
        while (last_x != '0 && guard < 1500) begin
            track_walk(1'b0);
            guard++;
        end
        for (int r = 0; r < 10; r++) begin
            track_walk(1'b0);
        end
        assert (last_x == '0) else report_mismatch($sformatf("left walk stuck at x %0d", last_x));
        left <= 1'b0;
        skip_cycles(12);

        // up away from the ladder does nothing
        up <= 1'b1;
        skip_cycles(30);
        position_now(x, y);
        assert (x == '0 && y == START_YPOS)
            else report_mismatch($sformatf("up off ladder moved to (%0d,%0d)", x, y));
        status_now(st);
        assert (!st.on_ladder) else report_mismatch("on_ladder set off the ladder");
        up <= 1'b0;
        skip_cycles(8);

        position_now(x, y0);
        jump <= 1'b1;
        skip_cycles(8);
        jump <= 1'b0;
        seen_air = 1'b0;
        min_y    = y0;
        guard    = 0;
        do begin
            status_now(st);
            position_now(x, y);
            if (st.airborne) begin
                seen_air = 1'b1;
            end
            if (y < min_y) begin
                min_y = y;
            end
            assert (y <= y0 && y >= y0 - JUMP_HEIGHT)
                else report_mismatch($sformatf("jump y %0d outside %0d..%0d", y, y0 - JUMP_HEIGHT, y0));
            guard++;
        end while (!(seen_air && !st.airborne) && guard < 200);
        assert (seen_air) else count_failure("airborne never set during the jump");
        assert (!st.airborne) else count_failure("jump never landed");
        assert (min_y < y0) else report_mismatch("jump never left the floor");
        position_now(x, y);
        assert (y == y0) else report_mismatch($sformatf("landed at y %0d, took off at %0d", y, y0));

        // walk into the ladder column
        position_now(last_x, y);
        last_t = last_read;
        right <= 1'b1;
        guard = 0;
        while (last_x < LADDER_X_LO - 11'd16 && guard < 1000) begin
            track_walk(1'b1);
            guard++;
        end
        right <= 1'b0;
        skip_cycles(12);
        position_now(x, y);
        assert (x + CHAR_WIDTH > LADDER_X_LO && x < LADDER_X_HI)
            else count_failure($sformatf("could not stop in the ladder column, x %0d", x));

        up <= 1'b1;
        prev_y = y;
        guard  = 0;
        do begin
            position_now(x, y);
            assert (y <= prev_y && y >= FLOOR_Y1)
                else report_mismatch($sformatf("climb y %0d after %0d", y, prev_y));
            prev_y = y;
            guard++;
        end while (y != FLOOR_Y1 && guard < 400);
        skip_cycles(20);
        position_now(x, y);
        assert (y == FLOOR_Y1)
            else report_mismatch($sformatf("climb ended at y %0d, floor %0d", y, FLOOR_Y1));
        status_now(st);
        assert (st.on_ladder) else report_mismatch("on_ladder clear at the top of the ladder");
        up <= 1'b0;
        hit_to_start("on the ladder");

        // hit in mid air
        jump <= 1'b1;
        guard = 0;
        do begin
            status_now(st);
            guard++;
        end while (!st.airborne && guard < 20);
        jump <= 1'b0;
        assert (st.airborne) else count_failure("second jump never took off");
        skip_cycles(random_bits(4) + 1);
        hit_to_start("in a jump");

        for (int i = 0; i < 8; i++) begin
            a = wb_addr_t'(random_bits(2));
            bus_cycle(a, 1'b0, word);
            expect_word = (a == WB_ADDR_POS) ? {16'(START_YPOS), 16'(START_XPOS)} : 32'd0;
            assert (word == expect_word)
                else report_mismatch($sformatf("addr %0d read %h, expected %h", a, word, expect_word));
        end

        bus_cycle(WB_ADDR_POS, 1'b0, pos_word);
        bus_cycle(WB_ADDR_POS, 1'b1, word);
        bus_cycle(WB_ADDR_STATUS, 1'b1, word);
        bus_cycle(WB_ADDR_POS, 1'b0, word);
        assert (word == pos_word)
            else report_mismatch($sformatf("pos word %h after writes, was %h", word, pos_word));
        bus_cycle(WB_ADDR_STATUS, 1'b0, word);
        assert (word == 32'd0) else report_mismatch($sformatf("status word %h after writes", word));
        skip_cycles(4);

        $display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/char_pkg.sv
source/key_decoder.sv
source/map_control.sv
source/char_movement.sv
source/pos_wb_slave.sv
source/char_top.sv
tests/char_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the character testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=char_top_tb_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module char_top_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG_FILE"
exit 1
